/* Makefile */
# Verilator flow for the radio clock core

VERILATOR  ?= verilator
TOP        ?= tb_radio_core
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/radio_core_asserts.sv */
/*
 * concurrent checks on the radio core
 * readback timing, reset state and TX underrun
 */

`timescale 1ns/1ps
`default_nettype none

module radio_core_asserts import radio_core_pkg::*; (
   input wire logic                    radio_clk,
   input wire logic                    i_rst,
   input wire logic [NUM_DBOARDS-1:0]  i_rb_stb,
   input wire logic [NUM_DBOARDS-1:0]  o_rb_valid,
   input wire logic [NUM_DBOARDS-1:0]  i_tx_valid,
   input wire logic [NUM_DBOARDS-1:0]  o_tx_ready,
   input wire logic [SAMPLE_WIDTH-1:0] o_tx [NUM_DBOARDS]
);

   int fail_count = 0;   // failures seen so far

   // valid trails the strobe by exactly one cycle
   a_rb_valid: assert property (@(posedge radio_clk) disable iff (i_rst)
      o_rb_valid == $past(i_rb_stb))
      else begin
         fail_count++;
         $error("readback valid not one cycle after the strobe");
      end

   a_rb_reset: assert property (@(posedge radio_clk) i_rst |=> (o_rb_valid == '0))
      else begin
         fail_count++;
         $error("readback valid high in the cycle after reset");
      end

   // empty host stream sends zero
   for (genvar d = 0; d < NUM_DBOARDS; d++) begin : g_tx
      a_underrun: assert property (@(posedge radio_clk) disable iff (i_rst)
         (o_tx_ready[d] && !i_tx_valid[d]) |=> (o_tx[d] == '0))
         else begin
            fail_count++;
            $error("DAC sample not zero after an underrun on radio %0d", d);
         end
   end

endmodule

bind radio_core radio_core_asserts u_asserts (
   .radio_clk(radio_clk), .i_rst(i_rst),
   .i_rb_stb(i_rb_stb), .o_rb_valid(o_rb_valid),
   .i_tx_valid(i_tx_valid), .o_tx_ready(o_tx_ready), .o_tx(o_tx)
);

`default_nettype wire

/* bench/tb_radio_core.sv */
/*
 * testbench for the radio clock core
 * settings writes, front panel mux, readback and DAC source selection
 */

`timescale 1ns/1ps
`default_nettype none

module tb_radio_core import radio_core_pkg::*; ();

   logic                                  radio_clk;
   logic                                  i_rst;
   logic [NUM_DBOARDS-1:0]                set_stb;
   logic [SET_ADDR_WIDTH-1:0]             set_addr [NUM_DBOARDS];
   logic [SET_DATA_WIDTH-1:0]             set_data [NUM_DBOARDS];
   logic [NUM_DBOARDS-1:0]                rb_stb;
   logic [SET_ADDR_WIDTH-1:0]             rb_addr [NUM_DBOARDS];
   logic [NUM_DBOARDS-1:0]                rb_valid;
   logic [RB_DATA_WIDTH-1:0]              rb_data [NUM_DBOARDS];
   logic [31:0]                           db_gpio_in [NUM_DBOARDS];
   logic [31:0]                           db_gpio_out [NUM_DBOARDS];
   logic [31:0]                           db_gpio_ddr [NUM_DBOARDS];
   logic [31:0]                           misc_in [NUM_DBOARDS];
   logic [31:0]                           misc_out [NUM_DBOARDS];
   logic [2:0]                            leds [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               rx [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               rx_data [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               tx [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               tx_data [NUM_DBOARDS];
   logic [NUM_DBOARDS-1:0]                tx_valid;
   logic [NUM_DBOARDS-1:0]                tx_ready;
   logic [FP_GPIO_WIDTH*FP_SRC_WIDTH-1:0] fp_src;
   logic [FP_GPIO_WIDTH-1:0]              fp_in;
   logic [FP_GPIO_WIDTH-1:0]              fp_out;
   logic [FP_GPIO_WIDTH-1:0]              fp_ddr;

   // expected state
   logic [31:0]                           exp_reg [NUM_DBOARDS][6];   // in offset order
   logic [1:0]                            src_model [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               exp_tx [NUM_DBOARDS];
   logic [SAMPLE_WIDTH-1:0]               exp_rx [NUM_DBOARDS];
   logic                                  checks_on;
   integer                                seed;

   radio_core u_dut (
      .radio_clk(radio_clk), .i_rst(i_rst),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_rb_stb(rb_stb), .i_rb_addr(rb_addr), .o_rb_valid(rb_valid), .o_rb_data(rb_data),
      .i_db_gpio_in(db_gpio_in), .o_db_gpio_out(db_gpio_out), .o_db_gpio_ddr(db_gpio_ddr),
      .i_misc_in(misc_in), .o_misc_out(misc_out), .o_leds(leds),
      .i_rx(rx), .o_rx_data(rx_data), .o_tx(tx),
      .i_tx_data(tx_data), .i_tx_valid(tx_valid), .o_tx_ready(tx_ready),
      .i_fp_gpio_src(fp_src), .i_fp_gpio_in(fp_in),
      .o_fp_gpio_out(fp_out), .o_fp_gpio_ddr(fp_ddr)
   );

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;
   end

   function automatic logic [31:0] rand32();
      return $random(seed);
   endfunction

   // DAC sample expected from the source rules
   function automatic logic [SAMPLE_WIDTH-1:0] ref_tx_sample(logic [1:0] src, logic valid,
      logic [SAMPLE_WIDTH-1:0] host, logic [SAMPLE_WIDTH-1:0] rx_prev);
      case (src)
         TX_SRC_HOST: ref_tx_sample = valid ? host : '0;   // underrun gives zero
         TX_SRC_LOOP: ref_tx_sample = rx_prev;
         default:     ref_tx_sample = '0;
      endcase
   endfunction

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report(string name, logic [63:0] got, logic [63:0] want);
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
      stop_run();
   endtask

   task automatic check_word(string name, logic [31:0] got, logic [31:0] want);
      if (got !== want) report(name, 64'(got), 64'(want));
   endtask

   task automatic check_rb(string name, logic [RB_DATA_WIDTH-1:0] got,
      logic [RB_DATA_WIDTH-1:0] want);
      if (got !== want) report(name, got, want);
   endtask

   task automatic check_fp(string name, logic [FP_GPIO_WIDTH-1:0] got,
      logic [FP_GPIO_WIDTH-1:0] want);
      if (got !== want) report(name, 64'(got), 64'(want));
   endtask

   task automatic check_tx(string name, logic [SAMPLE_WIDTH-1:0] got,
      logic [SAMPLE_WIDTH-1:0] want);
      if (got !== want) report(name, 64'(got), 64'(want));
   endtask

   task automatic check_regs();
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         check_word("o_db_gpio_out", db_gpio_out[d], exp_reg[d][0]);
         check_word("o_db_gpio_ddr", db_gpio_ddr[d], exp_reg[d][1]);
         check_word("o_misc_out", misc_out[d], exp_reg[d][4]);
         check_word("o_leds", {29'b0, leds[d]}, {29'b0, exp_reg[d][5][2:0]});
      end
   endtask

   // pin p follows db0 only when its field is zero
   function automatic logic [FP_GPIO_WIDTH-1:0] fp_pick(logic [31:0] db0, logic [31:0] db1);
      logic [FP_GPIO_WIDTH-1:0] pins;
      for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
         pins[p] = (fp_src[FP_SRC_WIDTH*p +: FP_SRC_WIDTH] == 2'b00) ? db0[p] : db1[p];
      end
      return pins;
   endfunction

   task automatic bus_write(int d, logic [SET_ADDR_WIDTH-1:0] addr, logic [31:0] data);
      set_stb[d] = 1'b1;
      set_addr[d] = addr;
      set_data[d] = data;
      @(negedge radio_clk);
      set_stb[d] = 1'b0;
   endtask

   task automatic read_check(int d, logic [SET_ADDR_WIDTH-1:0] addr,
      logic [RB_DATA_WIDTH-1:0] want);
      int waited;
      waited = 0;
      rb_stb[d] = 1'b1;
      rb_addr[d] = addr;
      @(negedge radio_clk);
      rb_stb[d] = 1'b0;
      while (!rb_valid[d]) begin
         if (waited == 4) begin
            $display("no readback valid from board %0d within 4 cycles", d);
            stop_run();
         end
         @(negedge radio_clk);
         waited++;
      end
      check_rb("o_rb_data", rb_data[d], want);
   endtask

   // ------------------------------
   // model and per-cycle compare
   // ------------------------------
   always @(posedge radio_clk) begin
      checks_on <= !i_rst;
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         exp_rx[d] <= i_rst ? '0 : rx[d];
         exp_tx[d] <= i_rst ? '0 : ref_tx_sample(src_model[d], tx_valid[d], tx_data[d], rx[d]);
         if (i_rst) begin
            src_model[d] <= TX_SRC_HOST;
         end else if (set_stb[d] && set_addr[d] == SR_TX_SRC) begin
            src_model[d] <= set_data[d][1:0];
         end
      end
   end

   always @(negedge radio_clk) begin
      if (u_dut.u_asserts.fail_count != 0) begin
         $display("a bound assertion on the core failed");
         stop_run();
      end
      if (checks_on) begin
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            check_tx("o_tx", tx[d], exp_tx[d]);
            check_tx("o_rx_data", rx_data[d], exp_rx[d]);
            check_word("o_tx_ready", {31'b0, tx_ready[d]}, {31'b0, src_model[d] == TX_SRC_HOST});
         end
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   initial begin
      logic [31:0] rnd;
      seed = 32'h7648608d;
      i_rst = 1'b1;
      set_stb = '0;
      rb_stb = '0;
      tx_valid = '0;
      fp_src = '0;
      fp_in = '0;
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         set_addr[d] = '0;
         set_data[d] = '0;
         rb_addr[d] = '0;
         db_gpio_in[d] = '0;
         misc_in[d] = '0;
         rx[d] = '0;
         tx_data[d] = '0;
         for (int k = 0; k < 6; k++) exp_reg[d][k] = '0;
      end
      repeat (2) @(posedge radio_clk);
      @(negedge radio_clk);
      i_rst = 1'b0;
      @(negedge radio_clk);

      // reset state, o_tx covered by the compare process
      check_regs();
      check_fp("o_fp_gpio_out", fp_out, '0);
      check_fp("o_fp_gpio_ddr", fp_ddr, '0);
      check_word("o_rb_valid", {30'b0, rb_valid}, '0);
      check_word("o_tx_ready", {30'b0, tx_ready}, 32'd3);

      // each write checked on both boards
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         for (int k = 0; k < 6; k++) begin
            rnd = rand32();
            bus_write(d, SR_DB_BASE + 8'(k), rnd);
            exp_reg[d][k] = rnd;
            check_regs();
         end
      end

      repeat (8) begin
         rnd = rand32();
         fp_src = rnd[23:0];
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            for (int k = 2; k < 4; k++) begin   // panel out and ddr
               rnd = rand32();
               bus_write(d, SR_DB_BASE + 8'(k), rnd);
               exp_reg[d][k] = rnd;
            end
         end
         @(negedge radio_clk);   // register then mux
         check_fp("o_fp_gpio_out", fp_out, fp_pick(exp_reg[0][2], exp_reg[1][2]));
         check_fp("o_fp_gpio_ddr", fp_ddr, fp_pick(exp_reg[0][3], exp_reg[1][3]));
      end

      for (int d = 0; d < NUM_DBOARDS; d++) begin
         misc_in[d] = rand32();
         db_gpio_in[d] = rand32();
         rnd = rand32();
         fp_in = rnd[FP_GPIO_WIDTH-1:0];
         repeat (2) @(negedge radio_clk);   // misc capture
         read_check(d, RB_DB_STATUS, {misc_in[d], db_gpio_in[d]});
         read_check(d, RB_FP_STATUS, {20'b0, fp_in, exp_reg[d][5]});
         read_check(d, RB_DB_BASE + 8'd2, '0);
      end

      // host, loop, zero and code 3 on each radio
      for (int r = 0; r < NUM_DBOARDS; r++) begin
         for (int m = 0; m < 4; m++) begin
            rnd = rand32();
            bus_write(r, SR_TX_SRC, {rnd[31:2], 2'(m)});
            repeat (12) begin
               rnd = rand32();
               tx_valid = rnd[NUM_DBOARDS-1:0];
               for (int d = 0; d < NUM_DBOARDS; d++) begin
                  tx_data[d] = rand32();
                  rx[d] = rand32();
               end
               @(negedge radio_clk);
            end
         end
      end
      tx_valid = '0;
      repeat (2) @(negedge radio_clk);

      if (u_dut.u_asserts.fail_count != 0) begin
         $display("bound assertions on the core failed %0d times", u_dut.u_asserts.fail_count);
         stop_run();
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* rtl/db_control.sv */
/*
 * daughterboard control
 * settings registers for GPIO, front panel, misc and LEDs,
 * misc input capture and status readback for one board
 */

`timescale 1ns/1ps
`default_nettype none

module db_control import radio_core_pkg::*; (
   input  wire logic                      i_rst,
   input  wire logic                      radio_clk,
   // settings bus
   input  wire logic                      i_set_stb,
   input  wire logic [SET_ADDR_WIDTH-1:0] i_set_addr,
   input  wire logic [SET_DATA_WIDTH-1:0] i_set_data,
   // readback
   input  wire logic                      i_rb_stb,
   input  wire logic [SET_ADDR_WIDTH-1:0] i_rb_addr,
   output logic                           o_rb_valid,
   output logic [RB_DATA_WIDTH-1:0]       o_rb_data,
   // daughterboard GPIO
   input  wire logic [31:0]               i_db_gpio_in,
   output logic [31:0]                    o_db_gpio_out,
   output logic [31:0]                    o_db_gpio_ddr,
   // front panel GPIO
   input  wire logic [FP_GPIO_WIDTH-1:0]  i_fp_gpio_in,
   output logic [FP_GPIO_WIDTH-1:0]       o_fp_gpio_out,
   output logic [FP_GPIO_WIDTH-1:0]       o_fp_gpio_ddr,
   // misc
   input  wire logic [31:0]               i_misc_in,
   output logic [31:0]                    o_misc_out,
   output logic [2:0]                     o_leds
);

   logic [31:0] leds_r;
   logic [31:0] misc_in_r;

   // ------------------------------
   // settings registers
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_misc_out    <= '0;
         leds_r        <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            SR_DB_BASE + SR_DB_GPIO_OUT: o_db_gpio_out <= i_set_data;
            SR_DB_BASE + SR_DB_GPIO_DDR: o_db_gpio_ddr <= i_set_data;
            SR_DB_BASE + SR_FP_GPIO_OUT: o_fp_gpio_out <= i_set_data[FP_GPIO_WIDTH-1:0];
            SR_DB_BASE + SR_FP_GPIO_DDR: o_fp_gpio_ddr <= i_set_data[FP_GPIO_WIDTH-1:0];
            SR_DB_BASE + SR_MISC_OUT:    o_misc_out    <= i_set_data;
            SR_DB_BASE + SR_LEDS:        leds_r        <= i_set_data;
            default: ;                   // not ours, front end decodes its own
         endcase
      end
   end

   assign o_leds = leds_r[2:0];   // {rx, txrx_tx, txrx_rx}

   // misc inputs come straight off the connector
   always_ff @(posedge radio_clk) begin
      misc_in_r <= i_misc_in;
   end

   // ------------------------------
   // readback
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= i_rb_stb;   // one cycle after the strobe
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) begin
         case (i_rb_addr)
            RB_DB_STATUS: o_rb_data <= {misc_in_r, i_db_gpio_in};
            RB_FP_STATUS: begin
               o_rb_data <= {{(SET_DATA_WIDTH-FP_GPIO_WIDTH){1'b0}}, i_fp_gpio_in, leds_r};
            end
            default:      o_rb_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/fe_data_map.sv */
/*
 * radio front end data mapping for one radio
 * RX pass-through and DAC sample selection from host stream,
 * RX loopback or zero
 */

`timescale 1ns/1ps
`default_nettype none

module fe_data_map import radio_core_pkg::*; (
   input  wire logic                      radio_clk,
   input  wire logic                      i_rst,
   // settings bus, shared with db_control
   input  wire logic                      i_set_stb,
   input  wire logic [SET_ADDR_WIDTH-1:0] i_set_addr,
   input  wire logic [SET_DATA_WIDTH-1:0] i_set_data,
   // ADC side
   input  wire logic [SAMPLE_WIDTH-1:0]   i_rx,
   output logic [SAMPLE_WIDTH-1:0]        o_rx_data,
   // host TX stream
   input  wire logic [SAMPLE_WIDTH-1:0]   i_tx_data,
   input  wire logic                      i_tx_valid,
   output logic                           o_tx_ready,
   // DAC side
   output logic [SAMPLE_WIDTH-1:0]        o_tx
);

   tx_src_e src_r;

   // ------------------------------
   // source register
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         src_r <= TX_SRC_HOST;
      end else if (i_set_stb && (i_set_addr == SR_TX_SRC)) begin
         src_r <= tx_src_e'(i_set_data[1:0]);   // low two bits only
      end
   end

   // only the host mode pulls from the stream
   assign o_tx_ready = (src_r == TX_SRC_HOST);

   // ------------------------------
   // sample path
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx_data <= '0;
      end else begin
         o_rx_data <= i_rx;
      end
   end

   // DAC never stalls, an empty stream sends zero
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_tx <= '0;
      end else begin
         case (src_r)
            TX_SRC_HOST: begin
               if (i_tx_valid && o_tx_ready) begin
                  o_tx <= i_tx_data;
               end else begin
                  o_tx <= '0;       // underrun
               end
            end
            TX_SRC_LOOP: o_tx <= i_rx;
            default:     o_tx <= '0;    // zero and code 3
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/fp_gpio_mux.sv */
/*
 * front panel GPIO source mux
 * picks daughterboard 0 or 1 per pin for output and direction
 */

`timescale 1ns/1ps
`default_nettype none

module fp_gpio_mux import radio_core_pkg::*; (
   input  wire logic                                  radio_clk,
   input  wire logic                                  i_rst,
   input  wire logic [FP_GPIO_WIDTH*FP_SRC_WIDTH-1:0] i_fp_gpio_src,
   input  wire logic [FP_GPIO_WIDTH-1:0]              i_fp_out [NUM_DBOARDS],
   input  wire logic [FP_GPIO_WIDTH-1:0]              i_fp_ddr [NUM_DBOARDS],
   output logic [FP_GPIO_WIDTH-1:0]                   o_fp_gpio_out,
   output logic [FP_GPIO_WIDTH-1:0]                   o_fp_gpio_ddr
);

   logic [FP_GPIO_WIDTH*FP_SRC_WIDTH-1:0] src_r;

   // input register for the source word
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         src_r <= '0;
      end else begin
         src_r <= i_fp_gpio_src;
      end
   end

   // field 0 selects db0, anything else db1
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
            if (src_r[FP_SRC_WIDTH*p +: FP_SRC_WIDTH] == '0) begin
               o_fp_gpio_out[p] <= i_fp_out[0][p];
               o_fp_gpio_ddr[p] <= i_fp_ddr[0][p];
            end else begin
               o_fp_gpio_out[p] <= i_fp_out[1][p];
               o_fp_gpio_ddr[p] <= i_fp_ddr[1][p];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/radio_core.sv */
/*
 * radio clock core
 * two daughterboard controls, two front end data maps
 * and the front panel GPIO source mux
 */

`timescale 1ns/1ps
`default_nettype none

module radio_core import radio_core_pkg::*; (
   input  wire logic                                  radio_clk,
   input  wire logic                                  i_rst,
   // settings and readback, one bus per daughterboard
   input  wire logic [NUM_DBOARDS-1:0]                i_set_stb,
   input  wire logic [SET_ADDR_WIDTH-1:0]             i_set_addr [NUM_DBOARDS],
   input  wire logic [SET_DATA_WIDTH-1:0]             i_set_data [NUM_DBOARDS],
   input  wire logic [NUM_DBOARDS-1:0]                i_rb_stb,
   input  wire logic [SET_ADDR_WIDTH-1:0]             i_rb_addr [NUM_DBOARDS],
   output logic [NUM_DBOARDS-1:0]                     o_rb_valid,
   output logic [RB_DATA_WIDTH-1:0]                   o_rb_data [NUM_DBOARDS],
   // daughterboard pins
   input  wire logic [31:0]                           i_db_gpio_in [NUM_DBOARDS],
   output logic [31:0]                                o_db_gpio_out [NUM_DBOARDS],
   output logic [31:0]                                o_db_gpio_ddr [NUM_DBOARDS],
   input  wire logic [31:0]                           i_misc_in [NUM_DBOARDS],
   output logic [31:0]                                o_misc_out [NUM_DBOARDS],
   output logic [2:0]                                 o_leds [NUM_DBOARDS],
   // converters
   input  wire logic [SAMPLE_WIDTH-1:0]               i_rx [NUM_DBOARDS],
   output logic [SAMPLE_WIDTH-1:0]                    o_rx_data [NUM_DBOARDS],
   output logic [SAMPLE_WIDTH-1:0]                    o_tx [NUM_DBOARDS],
   // host TX stream
   input  wire logic [SAMPLE_WIDTH-1:0]               i_tx_data [NUM_DBOARDS],
   input  wire logic [NUM_DBOARDS-1:0]                i_tx_valid,
   output logic [NUM_DBOARDS-1:0]                     o_tx_ready,
   // front panel
   input  wire logic [FP_GPIO_WIDTH*FP_SRC_WIDTH-1:0] i_fp_gpio_src,
   input  wire logic [FP_GPIO_WIDTH-1:0]              i_fp_gpio_in,
   output logic [FP_GPIO_WIDTH-1:0]                   o_fp_gpio_out,
   output logic [FP_GPIO_WIDTH-1:0]                   o_fp_gpio_ddr
);

   // per board front panel requests, resolved by the mux
   logic [FP_GPIO_WIDTH-1:0] fp_out [NUM_DBOARDS];
   logic [FP_GPIO_WIDTH-1:0] fp_ddr [NUM_DBOARDS];

   // ------------------------------
   // per daughterboard slices
   // ------------------------------
   for (genvar d = 0; d < NUM_DBOARDS; d++) begin : g_db
      db_control u_db_control (
         .i_rst(i_rst), .radio_clk(radio_clk),
         .i_set_stb(i_set_stb[d]), .i_set_addr(i_set_addr[d]), .i_set_data(i_set_data[d]),
         .i_rb_stb(i_rb_stb[d]), .i_rb_addr(i_rb_addr[d]),
         .o_rb_valid(o_rb_valid[d]), .o_rb_data(o_rb_data[d]),
         .i_db_gpio_in(i_db_gpio_in[d]),
         .o_db_gpio_out(o_db_gpio_out[d]), .o_db_gpio_ddr(o_db_gpio_ddr[d]),
         .i_fp_gpio_in(i_fp_gpio_in),   // every board sees all panel inputs
         .o_fp_gpio_out(fp_out[d]), .o_fp_gpio_ddr(fp_ddr[d]),
         .i_misc_in(i_misc_in[d]), .o_misc_out(o_misc_out[d]),
         .o_leds(o_leds[d])
      );

      fe_data_map u_fe_data_map (
         .radio_clk(radio_clk), .i_rst(i_rst),
         .i_set_stb(i_set_stb[d]), .i_set_addr(i_set_addr[d]), .i_set_data(i_set_data[d]),
         .i_rx(i_rx[d]), .o_rx_data(o_rx_data[d]),
         .i_tx_data(i_tx_data[d]), .i_tx_valid(i_tx_valid[d]), .o_tx_ready(o_tx_ready[d]),
         .o_tx(o_tx[d])
      );
   end

   // front panel source mux
   fp_gpio_mux u_fp_gpio_mux (
      .radio_clk(radio_clk),
      .i_rst(i_rst),
      .i_fp_gpio_src(i_fp_gpio_src),
      .i_fp_out(fp_out),
      .i_fp_ddr(fp_ddr),
      .o_fp_gpio_out(o_fp_gpio_out),
      .o_fp_gpio_ddr(o_fp_gpio_ddr)
   );

endmodule

`default_nettype wire

/* rtl/radio_core_pkg.sv */
/*
 * radio core shared definitions
 * bus widths, settings and readback addresses, TX source codes
 */

`default_nettype none

package radio_core_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int NUM_DBOARDS    = 2;
   localparam int FP_GPIO_WIDTH  = 12;
   localparam int FP_SRC_WIDTH   = 2;    // source select bits per pin
   localparam int SAMPLE_WIDTH   = 32;   // 16b I over 16b Q
   localparam int SET_ADDR_WIDTH = 8;
   localparam int SET_DATA_WIDTH = 32;
   localparam int RB_DATA_WIDTH  = 64;

   // ------------------------------
   // settings bus map
   // ------------------------------
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_BASE      = 8'd160;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_GPIO_OUT  = 8'd0;   // offsets from base
   localparam logic [SET_ADDR_WIDTH-1:0] SR_DB_GPIO_DDR  = 8'd1;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_GPIO_OUT  = 8'd2;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_FP_GPIO_DDR  = 8'd3;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_MISC_OUT     = 8'd4;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_LEDS         = 8'd5;
   localparam logic [SET_ADDR_WIDTH-1:0] SR_TX_SRC       = SR_DB_BASE + 8'd48;

   // readback map
   localparam logic [SET_ADDR_WIDTH-1:0] RB_DB_BASE      = 8'd16;
   localparam logic [SET_ADDR_WIDTH-1:0] RB_DB_STATUS    = RB_DB_BASE + 8'd0;
   localparam logic [SET_ADDR_WIDTH-1:0] RB_FP_STATUS    = RB_DB_BASE + 8'd1;

   // DAC sample source, code 3 acts like zero
   typedef enum logic [1:0] {
      TX_SRC_HOST = 2'd0,
      TX_SRC_LOOP = 2'd1,
      TX_SRC_ZERO = 2'd2
   } tx_src_e;

endpackage

`default_nettype wire

/* verilog.f */
rtl/radio_core_pkg.sv
rtl/db_control.sv
rtl/fp_gpio_mux.sv
rtl/fe_data_map.sv
rtl/radio_core.sv
bench/radio_core_asserts.sv
bench/tb_radio_core.sv
